// File: compile.f
+incdir+verif
verilog/rv_pkg.sv
verilog/rv_regfile.sv
verilog/rv_fetch.sv
verilog/rv_hazard.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_memory.sv
verilog/rv_core.sv
verif/tb_rv_core.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator, exit status follows the result
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_rv_core \
    -o sim_rv_core > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_rv_core > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// File: verif/tb_rv_model.svh
// instruction level reference model and stimulus helpers, included inside the core testbench
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// galois lfsr, one step per random bit
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// initial data memory contents, every address bit shows up
function automatic word_t fill_word(input logic [7:0] idx);
    return {idx, ~idx, idx ^ 8'h3c, 8'ha5};
endfunction

// integer ops as the ISA defines them
function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                  input word_t a, input word_t b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd4: return a ^ b;
        3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

// ----------------------------------------
// run the program, record stores and loads
// ----------------------------------------
function automatic void run_model();
    word_t      x [32];
    word_t      m [256];
    word_t      pc;
    word_t      nxt;
    word_t      ins;
    word_t      res;
    word_t      addr;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      a;
    word_t      b;
    logic       wr;
    logic [6:0] opc;
    logic [2:0] f3;
    dmem_req_t  req;
    for (int i = 0; i < 32; i++) begin
        x[5'(i)] = '0;
    end
    for (int i = 0; i < 256; i++) begin
        m[8'(i)] = fill_word(8'(i));
    end
    pc = '0;
    for (int step = 0; step < 2000; step++) begin
        ins = imem[pc[9:2]];
        // jal x0,0 ends the program
        if (ins == 32'h0000_006f) begin
            break;
        end
        opc   = ins[6:0];
        f3    = ins[14:12];
        a     = x[ins[19:15]];
        b     = x[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nxt   = pc + 32'd4;
        wr    = 1'b0;
        res   = '0;
        case (opc)
            OPC_R_TYPE: begin
                res = alu_ref(f3, ins[30], a, b);
                wr  = 1'b1;
            end
            OPC_I_TYPE: begin
                res = alu_ref(f3, (f3 == 3'd5) && ins[30], a, imm_i);
                wr  = 1'b1;
            end
            OPC_LOAD: begin
                addr = a + imm_i;
                res  = m[addr[9:2]];
                wr   = 1'b1;
                exp_ld.push_back(res);
            end
            OPC_STORE: begin
                addr = a + imm_s;
                m[addr[9:2]] = b;
                req = '{rd_en: 1'b0, wr_en: 1'b1, addr: addr[31:2], wdata: b};
                exp_st.push_back(req);
            end
            OPC_BRANCH: begin
                if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b)) begin
                    nxt = pc + imm_b;
                end
            end
            OPC_JAL: begin
                res = pc + 32'd4;
                wr  = 1'b1;
                nxt = pc + imm_j;
            end
            OPC_JALR: begin
                res = pc + 32'd4;
                wr  = 1'b1;
                nxt = (a + imm_i) & ~32'd1;
            end
            default: ;
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            x[ins[11:7]] = res;
        end
        pc = nxt;
    end
endfunction

`endif

// File: verif/tb_rv_core.sv
// core testbench that runs a fixed program against the reference model under random data stalls
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    logic      clk;
    logic      rst_n;
    pc_t       imem_addr;
    word_t     imem_rdata;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;
    logic      dmem_stall;

    word_t       imem [256];
    word_t       dmem [256];
    dmem_req_t   exp_st [$];
    word_t       exp_ld [$];
    int          st_idx;
    int          ld_idx;
    logic [7:0]  prog_idx;
    logic [15:0] lfsr;
    logic        bit0;
    logic        bit1;
    int          cycles;

    `include "tb_rv_model.svh"

    rv_core #(
        .RESET_PC (30'd0)
    ) u_rv_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .dmem_stall (dmem_stall)
    );

    always #2 clk = ~clk;

    // both memories answer combinationally
    assign imem_rdata = imem[imem_addr[7:0]];
    assign dmem_rdata = dmem[dmem_req.addr[7:0]];

    // ----------------------------------------
    // instruction encoders
    // ----------------------------------------
    function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_R_TYPE};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t b_type(input logic [12:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t j_type(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic emit(input word_t ins);
        imem[prog_idx] = ins;
        prog_idx = prog_idx + 8'd1;
    endtask

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_dmem_req(input dmem_req_t got, input dmem_req_t exp);
        if (got !== exp) begin
            $display("ERR dmem_req got %h exp %h", got, exp);
            fail_now("data memory request mismatch");
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", name, got, exp);
            fail_now("data word mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", name, got, exp);
            fail_now("control flag mismatch");
        end
    endtask

    task automatic load_program();
        // alu ops with a store after each and forwarding from every stage
        emit(i_type(12'd100, 5'd0, 3'd0, 5'd1, OPC_I_TYPE));
        emit(i_type(12'hff9, 5'd0, 3'd0, 5'd2, OPC_I_TYPE));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
        emit(s_type(12'd0, 5'd3, 5'd0));
        emit(r_type(7'h20, 5'd1, 5'd2, 3'd0, 5'd4));
        emit(s_type(12'd4, 5'd4, 5'd0));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'd7, 5'd5));
        emit(s_type(12'd8, 5'd5, 5'd0));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'd6, 5'd6));
        emit(s_type(12'd12, 5'd6, 5'd0));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'd4, 5'd7));
        emit(s_type(12'd16, 5'd7, 5'd0));
        // shift amount 35 uses only the low five bits
        emit(i_type(12'd35, 5'd0, 3'd0, 5'd8, OPC_I_TYPE));
        emit(r_type(7'h00, 5'd8, 5'd2, 3'd1, 5'd9));
        emit(s_type(12'd20, 5'd9, 5'd0));
        emit(r_type(7'h00, 5'd8, 5'd2, 3'd5, 5'd10));
        emit(s_type(12'd24, 5'd10, 5'd0));
        emit(r_type(7'h20, 5'd8, 5'd2, 3'd5, 5'd11));
        emit(s_type(12'd28, 5'd11, 5'd0));
        emit(r_type(7'h00, 5'd1, 5'd2, 3'd2, 5'd12));
        emit(s_type(12'd32, 5'd12, 5'd0));
        emit(i_type(12'h004, 5'd2, 3'd1, 5'd13, OPC_I_TYPE));
        emit(i_type(12'h401, 5'd13, 3'd5, 5'd14, OPC_I_TYPE));
        emit(s_type(12'd36, 5'd14, 5'd0));
        // load-use into an add
        emit(i_type(12'd0, 5'd0, 3'd2, 5'd15, OPC_LOAD));
        emit(r_type(7'h00, 5'd1, 5'd15, 3'd0, 5'd16));
        emit(s_type(12'd40, 5'd16, 5'd0));
        // branches and jumps whose skipped stores must never appear
        emit(b_type(13'd8, 5'd1, 5'd1, 3'd0));
        emit(s_type(12'd44, 5'd1, 5'd0));
        emit(b_type(13'd8, 5'd1, 5'd1, 3'd1));
        emit(s_type(12'd48, 5'd2, 5'd0));
        emit(j_type(21'd8, 5'd17));
        emit(s_type(12'd52, 5'd2, 5'd0));
        emit(s_type(12'd56, 5'd17, 5'd0));
        emit(i_type(12'd152, 5'd0, 3'd0, 5'd18, OPC_I_TYPE));
        emit(i_type(12'd0, 5'd18, 3'd0, 5'd19, OPC_JALR));
        emit(s_type(12'd60, 5'd1, 5'd0));
        emit(i_type(12'd1, 5'd0, 3'd0, 5'd20, OPC_I_TYPE));
        emit(s_type(12'd64, 5'd19, 5'd0));
        // load straight into store data
        emit(i_type(12'd40, 5'd0, 3'd2, 5'd20, OPC_LOAD));
        emit(s_type(12'd68, 5'd20, 5'd0));
        emit(i_type(12'h055, 5'd20, 3'd4, 5'd21, OPC_I_TYPE));
        emit(i_type(12'hf00, 5'd21, 3'd6, 5'd22, OPC_I_TYPE));
        emit(i_type(12'h7f0, 5'd22, 3'd7, 5'd23, OPC_I_TYPE));
        emit(s_type(12'd72, 5'd23, 5'd0));
        emit(i_type(12'hffa, 5'd2, 3'd2, 5'd24, OPC_I_TYPE));
        emit(s_type(12'd76, 5'd24, 5'd0));
        // x25 reaches its consumer from write-back
        emit(i_type(12'd9, 5'd0, 3'd0, 5'd25, OPC_I_TYPE));
        emit(i_type(12'd1, 5'd0, 3'd0, 5'd26, OPC_I_TYPE));
        emit(i_type(12'd2, 5'd0, 3'd0, 5'd27, OPC_I_TYPE));
        emit(r_type(7'h00, 5'd26, 5'd25, 3'd0, 5'd28));
        emit(s_type(12'd80, 5'd28, 5'd0));
        // not-taken beq and taken bne
        emit(b_type(13'd8, 5'd2, 5'd1, 3'd0));
        emit(s_type(12'd84, 5'd2, 5'd0));
        emit(b_type(13'd8, 5'd2, 5'd1, 3'd1));
        emit(s_type(12'd88, 5'd1, 5'd0));
        emit(s_type(12'd92, 5'd28, 5'd0));
        emit(j_type(21'd0, 5'd0));
    endtask

    // random data stall from two lfsr bits per cycle
    always @(posedge clk) begin
        if (rst_n === 1'b1) begin
            #1;
            bit0 = lfsr[0];
            lfsr = lfsr_step(lfsr);
            bit1 = lfsr[0];
            lfsr = lfsr_step(lfsr);
            dmem_stall = bit0 & bit1;
        end
    end

    // ----------------------------------------
    // compare process for accepted requests only
    // ----------------------------------------
    always @(negedge clk) begin
        if (rst_n === 1'b1 && dmem_stall === 1'b0) begin
            if (dmem_req.wr_en === 1'b1) begin
                if (st_idx >= exp_st.size()) begin
                    fail_now("store seen beyond the expected sequence");
                end else begin
                    check_dmem_req(dmem_req, exp_st[st_idx]);
                    dmem[dmem_req.addr[7:0]] = dmem_req.wdata;
                    st_idx++;
                end
            end
            if (dmem_req.rd_en === 1'b1) begin
                if (ld_idx >= exp_ld.size()) begin
                    fail_now("load seen beyond the expected sequence");
                end else begin
                    check_word("dmem_rdata", dmem_rdata, exp_ld[ld_idx]);
                    ld_idx++;
                end
            end
        end
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        dmem_stall = 1'b0;
        lfsr       = 16'd19;
        st_idx     = 0;
        ld_idx     = 0;
        prog_idx   = 8'd0;
        for (int i = 0; i < 256; i++) begin
            imem[8'(i)] = NOP_INSTR;
            dmem[8'(i)] = fill_word(8'(i));
        end
        load_program();
        run_model();

        // enables idle through reset and the first cycles after it
        for (int i = 0; i < 19; i++) begin
            @(posedge clk);
            #1;
            if (i == 15) begin
                rst_n = 1'b1;
            end
            if (i > 0) begin
                check_flag("dmem_req.rd_en", dmem_req.rd_en, 1'b0);
                check_flag("dmem_req.wr_en", dmem_req.wr_en, 1'b0);
            end
        end

        cycles = 0;
        while (st_idx < exp_st.size()) begin
            @(posedge clk);
            cycles++;
            if (cycles > 4000) begin
                fail_now("timeout waiting for the expected stores");
            end
        end
        // watch for late duplicates while the core spins
        for (int i = 0; i < 40; i++) begin
            @(posedge clk);
        end
        if (ld_idx != exp_ld.size()) begin
            fail_now("not every expected load was seen");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

// File: verilog/rv_core.sv
// core top level, wires the five pipeline stages to the instruction and data memory ports
`timescale 1ns/1ps

module rv_core #(
    parameter rv_pkg::pc_t RESET_PC = '0
) (
    input  logic              clk,
    input  logic              rst_n,
    output rv_pkg::pc_t       imem_addr,
    input  rv_pkg::word_t     imem_rdata,
    output rv_pkg::dmem_req_t dmem_req,
    input  rv_pkg::word_t     dmem_rdata,
    input  logic              dmem_stall
);
    import rv_pkg::*;

    word_t    id_instr;
    pc_t      id_pc;
    logic     redirect;
    pc_t      target;
    logic     load_use;
    logic     hold;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rd1;
    word_t    rd2;
    fwd_sel_e id_sel_a;
    fwd_sel_e id_sel_b;
    fwd_sel_e ex_sel_a;
    fwd_sel_e ex_sel_b;
    fwd_sel_e ex_sel_st;
    id_ex_t   ex;
    ex_mem_t  mem;
    mem_wb_t  wb;
    word_t    ex_result;
    word_t    mem_result;

    // front end also freezes for the load-use bubble
    assign hold = dmem_stall || load_use;
    assign rs1  = id_instr[19:15];
    assign rs2  = id_instr[24:20];

    rv_fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .hold       (hold),
        .redirect   (redirect),
        .target     (target),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .id_instr   (id_instr),
        .id_pc      (id_pc)
    );

    rv_regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd1   (rd1),
        .rd2   (rd2),
        .wb    (wb)
    );

    rv_hazard u_hazard (
        .id_instr  (id_instr),
        .ex        (ex),
        .mem       (mem),
        .wb        (wb),
        .id_sel_a  (id_sel_a),
        .id_sel_b  (id_sel_b),
        .ex_sel_a  (ex_sel_a),
        .ex_sel_b  (ex_sel_b),
        .ex_sel_st (ex_sel_st),
        .load_use  (load_use)
    );

    rv_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (dmem_stall),
        .id_instr   (id_instr),
        .id_pc      (id_pc),
        .rd1        (rd1),
        .rd2        (rd2),
        .id_sel_a   (id_sel_a),
        .id_sel_b   (id_sel_b),
        .ex_sel_a   (ex_sel_a),
        .ex_sel_b   (ex_sel_b),
        .ex_sel_st  (ex_sel_st),
        .load_use   (load_use),
        .ex_result  (ex_result),
        .mem_result (mem_result),
        .wb         (wb),
        .redirect   (redirect),
        .target     (target),
        .ex         (ex)
    );

    rv_execute u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (dmem_stall),
        .ex         (ex),
        .mem_result (mem_result),
        .wb_data    (wb.data),
        .ex_result  (ex_result),
        .mem        (mem)
    );

    rv_memory u_memory (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (dmem_stall),
        .mem        (mem),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .mem_result (mem_result),
        .wb         (wb)
    );

endmodule

// File: verilog/rv_decode.sv
// decode stage, builds controls and operands, resolves branches and jumps, feeds ID/EX
`timescale 1ns/1ps

module rv_decode (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stall,
    input  rv_pkg::word_t    id_instr,
    input  rv_pkg::pc_t      id_pc,
    input  rv_pkg::word_t    rd1,
    input  rv_pkg::word_t    rd2,
    input  rv_pkg::fwd_sel_e id_sel_a,
    input  rv_pkg::fwd_sel_e id_sel_b,
    input  rv_pkg::fwd_sel_e ex_sel_a,
    input  rv_pkg::fwd_sel_e ex_sel_b,
    input  rv_pkg::fwd_sel_e ex_sel_st,
    input  logic             load_use,
    input  rv_pkg::word_t    ex_result,
    input  rv_pkg::word_t    mem_result,
    input  rv_pkg::mem_wb_t  wb,
    output logic             redirect,
    output rv_pkg::pc_t      target,
    output rv_pkg::id_ex_t   ex
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_r;
    logic       is_i;
    logic       is_load;
    logic       is_store;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       taken;
    word_t      imm;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      byte_pc;
    word_t      br_sum;
    word_t      jalr_sum;
    alu_op_e    alu_op;
    id_ex_t     ex_next;

    function automatic word_t fwd_value(
        input fwd_sel_e sel,
        input word_t    reg_val,
        input word_t    from_ex,
        input word_t    from_mem,
        input word_t    from_wb
    );
        case (sel)
            FWD_EX:  return from_ex;
            FWD_MEM: return from_mem;
            FWD_WB:  return from_wb;
            default: return reg_val;
        endcase
    endfunction

    assign opcode    = id_instr[6:0];
    assign funct3    = id_instr[14:12];
    assign is_r      = (opcode == OPC_R_TYPE);
    assign is_i      = (opcode == OPC_I_TYPE);
    assign is_load   = (opcode == OPC_LOAD);
    assign is_store  = (opcode == OPC_STORE);
    assign is_branch = (opcode == OPC_BRANCH);
    assign is_jal    = (opcode == OPC_JAL);
    assign is_jalr   = (opcode == OPC_JALR);

    // ----------------------------------------
    // immediate and alu control
    // ----------------------------------------
    always_comb begin
        if (is_store) begin
            imm = {{20{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
        end else if (is_branch) begin
            imm = {{20{id_instr[31]}}, id_instr[7], id_instr[30:25], id_instr[11:8], 1'b0};
        end else if (is_jal) begin
            imm = {{12{id_instr[31]}}, id_instr[19:12], id_instr[20], id_instr[30:21], 1'b0};
        end else begin
            // shift immediates keep shamt in the low five bits
            imm = {{20{id_instr[31]}}, id_instr[31:20]};
        end
    end

    always_comb begin
        alu_op = ALU_NONE;
        if (is_r || is_i) begin
            case (funct3)
                3'b000:  alu_op = (is_r && id_instr[30]) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = id_instr[30] ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                3'b111:  alu_op = ALU_AND;
                default: alu_op = ALU_NONE;
            endcase
        end else if (is_load || is_store || is_jal || is_jalr) begin
            // address or link value
            alu_op = ALU_ADD;
        end
    end

    // ----------------------------------------
    // branch compare and jump target
    // ----------------------------------------
    assign rs1_val  = fwd_value(id_sel_a, rd1, ex_result, mem_result, wb.data);
    assign rs2_val  = fwd_value(id_sel_b, rd2, ex_result, mem_result, wb.data);
    assign byte_pc  = {id_pc, 2'b00};
    assign br_sum   = byte_pc + imm;
    assign jalr_sum = rs1_val + imm;

    assign taken = is_branch && ((funct3 == 3'b000 && rs1_val == rs2_val) ||
                                 (funct3 == 3'b001 && rs1_val != rs2_val));

    // operands may still be in flight from a load
    assign redirect = !load_use && (taken || is_jal || is_jalr);
    assign target   = is_jalr ? jalr_sum[31:2] : br_sum[31:2];

    // ----------------------------------------
    // ID/EX register
    // ----------------------------------------
    always_comb begin
        ex_next.rd        = id_instr[11:7];
        ex_next.reg_write = is_r || is_i || is_load || is_jal || is_jalr;
        ex_next.mem_read  = is_load;
        ex_next.mem_write = is_store;
        ex_next.alu_op    = alu_op;
        ex_next.st_data   = rs2_val;
        ex_next.sel_a     = ex_sel_a;
        ex_next.sel_b     = ex_sel_b;
        ex_next.sel_st    = ex_sel_st;
        if (is_jal || is_jalr) begin
            // link value is pc + 4
            ex_next.op_a = byte_pc;
            ex_next.op_b = 32'd4;
        end else begin
            ex_next.op_a = rs1_val;
            ex_next.op_b = is_r ? rs2_val : imm;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex <= '0;
        end else if (!stall) begin
            if (load_use) begin
                ex <= '0;
            end else begin
                ex <= ex_next;
            end
        end
    end

    // the load moves on after one bubble
    a_one_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        (load_use && !stall) |=> !load_use);

endmodule

// File: verilog/rv_execute.sv
// execute stage, operand forwarding, the ALU and the EX/MEM register
`timescale 1ns/1ps

module rv_execute (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  rv_pkg::id_ex_t  ex,
    input  rv_pkg::word_t   mem_result,
    input  rv_pkg::word_t   wb_data,
    output rv_pkg::word_t   ex_result,
    output rv_pkg::ex_mem_t mem
);
    import rv_pkg::*;

    word_t      op_a;
    word_t      op_b;
    word_t      st_data;
    logic [4:0] shamt;

    function automatic word_t pick(
        input fwd_sel_e sel,
        input word_t    own,
        input word_t    from_mem,
        input word_t    from_wb
    );
        case (sel)
            FWD_MEM: return from_mem;
            FWD_WB:  return from_wb;
            default: return own;
        endcase
    endfunction

    assign op_a    = pick(ex.sel_a, ex.op_a, mem_result, wb_data);
    assign op_b    = pick(ex.sel_b, ex.op_b, mem_result, wb_data);
    assign st_data = pick(ex.sel_st, ex.st_data, mem_result, wb_data);
    assign shamt   = op_b[4:0];

    // ----------------------------------------
    // ALU
    // ----------------------------------------
    always_comb begin
        case (ex.alu_op)
            ALU_ADD: ex_result = op_a + op_b;
            ALU_SUB: ex_result = op_a - op_b;
            ALU_AND: ex_result = op_a & op_b;
            ALU_OR:  ex_result = op_a | op_b;
            ALU_XOR: ex_result = op_a ^ op_b;
            ALU_SLL: ex_result = op_a << shamt;
            ALU_SRL: ex_result = op_a >> shamt;
            ALU_SRA: ex_result = word_t'($signed(op_a) >>> shamt);
            ALU_SLT: ex_result = {31'd0, $signed(op_a) < $signed(op_b)};
            default: ex_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem <= '0;
        end else if (!stall) begin
            mem.result    <= ex_result;
            mem.st_data   <= st_data;
            mem.rd        <= ex.rd;
            mem.reg_write <= ex.reg_write;
            mem.mem_read  <= ex.mem_read;
            mem.mem_write <= ex.mem_write;
        end
    end

endmodule

// File: verilog/rv_fetch.sv
// fetch stage that owns the program counter and the IF/ID register
`timescale 1ns/1ps

module rv_fetch #(
    parameter rv_pkg::pc_t RESET_PC = '0
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          hold,
    input  logic          redirect,
    input  rv_pkg::pc_t   target,
    output rv_pkg::pc_t   imem_addr,
    input  rv_pkg::word_t imem_rdata,
    output rv_pkg::word_t id_instr,
    output rv_pkg::pc_t   id_pc
);
    import rv_pkg::*;

    pc_t pc;

    // instruction memory answers in the same cycle
    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= RESET_PC;
            id_instr <= NOP_INSTR;
            id_pc    <= '0;
        end else if (!hold) begin
            if (redirect) begin
                pc <= target;
                // drop the instruction fetched behind the jump
                id_instr <= NOP_INSTR;
            end else begin
                pc       <= pc + 30'd1;
                id_instr <= imem_rdata;
            end
            id_pc <= pc;
        end
    end

    // the slot behind a jump holds a NOP so redirects never come back to back
    a_one_flush: assert property (@(posedge clk) disable iff (!rst_n)
        (redirect && !hold) |=> !redirect);

endmodule

// File: verilog/rv_hazard.sv
// hazard unit, forwarding selects for decode and execute and load-use detection
`timescale 1ns/1ps

module rv_hazard (
    input  rv_pkg::word_t    id_instr,
    input  rv_pkg::id_ex_t   ex,
    input  rv_pkg::ex_mem_t  mem,
    input  rv_pkg::mem_wb_t  wb,
    output rv_pkg::fwd_sel_e id_sel_a,
    output rv_pkg::fwd_sel_e id_sel_b,
    output rv_pkg::fwd_sel_e ex_sel_a,
    output rv_pkg::fwd_sel_e ex_sel_b,
    output rv_pkg::fwd_sel_e ex_sel_st,
    output logic             load_use
);
    import rv_pkg::*;

    logic [6:0] opcode;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic       alu_rs1;
    logic       alu_rs2;
    logic       st_rs2;
    logic       reads_rs1;
    logic       reads_rs2;

    function automatic logic hit(input reg_idx_t rs, input reg_idx_t rd, input logic we);
        return we && rd != '0 && rd == rs;
    endfunction

    // decode sees the producer where it sits now
    function automatic fwd_sel_e id_pick(
        input reg_idx_t rs,
        input id_ex_t   e,
        input ex_mem_t  m,
        input mem_wb_t  w
    );
        if (hit(rs, e.rd, e.reg_write) && !e.mem_read) begin
            return FWD_EX;
        end else if (hit(rs, m.rd, m.reg_write)) begin
            return FWD_MEM;
        end else if (hit(rs, w.rd, w.reg_write)) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    // execute sees it one stage further on
    function automatic fwd_sel_e ex_pick(
        input reg_idx_t rs,
        input logic     used,
        input id_ex_t   e,
        input ex_mem_t  m
    );
        if (used && hit(rs, e.rd, e.reg_write)) begin
            return FWD_MEM;
        end else if (used && hit(rs, m.rd, m.reg_write)) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign opcode = id_instr[6:0];
    assign rs1    = id_instr[19:15];
    assign rs2    = id_instr[24:20];

    // which fields are real register reads for this opcode
    assign alu_rs1   = opcode inside {OPC_R_TYPE, OPC_I_TYPE, OPC_LOAD, OPC_STORE};
    assign alu_rs2   = (opcode == OPC_R_TYPE);
    assign st_rs2    = (opcode == OPC_STORE);
    assign reads_rs1 = alu_rs1 || opcode == OPC_BRANCH || opcode == OPC_JALR;
    assign reads_rs2 = alu_rs2 || st_rs2 || opcode == OPC_BRANCH;

    assign id_sel_a  = id_pick(rs1, ex, mem, wb);
    assign id_sel_b  = id_pick(rs2, ex, mem, wb);
    assign ex_sel_a  = ex_pick(rs1, alu_rs1, ex, mem);
    assign ex_sel_b  = ex_pick(rs2, alu_rs2, ex, mem);
    assign ex_sel_st = ex_pick(rs2, st_rs2, ex, mem);

    assign load_use = ex.mem_read &&
                      ((reads_rs1 && hit(rs1, ex.rd, ex.reg_write)) ||
                       (reads_rs2 && hit(rs2, ex.rd, ex.reg_write)));

endmodule

// File: verilog/rv_memory.sv
// memory stage, drives the data memory request and the MEM/WB register
`timescale 1ns/1ps

module rv_memory (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  rv_pkg::ex_mem_t   mem,
    output rv_pkg::dmem_req_t dmem_req,
    input  rv_pkg::word_t     dmem_rdata,
    output rv_pkg::word_t     mem_result,
    output rv_pkg::mem_wb_t   wb
);
    import rv_pkg::*;

    // request stays steady while EX/MEM holds
    assign dmem_req.rd_en = mem.mem_read;
    assign dmem_req.wr_en = mem.mem_write;
    assign dmem_req.addr  = mem.result[31:2];
    assign dmem_req.wdata = mem.st_data;

    assign mem_result = mem.mem_read ? dmem_rdata : mem.result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb <= '0;
        end else if (stall) begin
            // bubble, data kept for execute forwarding across the stall
            wb.reg_write <= 1'b0;
        end else begin
            wb.data      <= mem_result;
            wb.rd        <= mem.rd;
            wb.reg_write <= mem.reg_write;
        end
    end

    a_req_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmem_req.rd_en && dmem_req.wr_en));

endmodule

// File: verilog/rv_pkg.sv
// shared widths, opcodes, enums and pipeline register layouts; compile before all core files
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    // instruction address in words, byte offset bits dropped
    typedef logic [29:0] pc_t;

    // ----------------------------------------
    // major opcodes
    // ----------------------------------------
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_R_TYPE = 7'b0110011;
    localparam logic [6:0] OPC_I_TYPE = 7'b0010011;

    // addi x0,x0,0
    localparam word_t NOP_INSTR = 32'h0000_0013;

    typedef enum logic [3:0] {
        ALU_NONE = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_AND  = 4'd3,
        ALU_OR   = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SLL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SLT  = 4'd9
    } alu_op_e;

    // operand source, regfile value unless a younger stage owns it
    typedef enum logic [1:0] {
        FWD_REG = 2'b00,
        FWD_EX  = 2'b01,
        FWD_MEM = 2'b10,
        FWD_WB  = 2'b11
    } fwd_sel_e;

    // ----------------------------------------
    // pipeline registers
    // ----------------------------------------
    typedef struct packed {
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        alu_op_e  alu_op;
        word_t    op_a;
        word_t    op_b;
        word_t    st_data;
        fwd_sel_e sel_a;
        fwd_sel_e sel_b;
        fwd_sel_e sel_st;
    } id_ex_t;

    typedef struct packed {
        word_t    result;
        word_t    st_data;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
    } ex_mem_t;

    typedef struct packed {
        word_t    data;
        reg_idx_t rd;
        logic     reg_write;
    } mem_wb_t;

    typedef struct packed {
        logic  rd_en;
        logic  wr_en;
        pc_t   addr;
        word_t wdata;
    } dmem_req_t;

endpackage

// File: verilog/rv_regfile.sv
// integer register file, two combinational reads and one write from write-back
`timescale 1ns/1ps

module rv_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_idx_t  rs1,
    input  rv_pkg::reg_idx_t  rs2,
    output rv_pkg::word_t     rd1,
    output rv_pkg::word_t     rd2,
    input  rv_pkg::mem_wb_t   wb
);
    import rv_pkg::*;

    word_t regs [32];

    // x0 is never written, so it reads zero after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // no internal bypass, the hazard unit selects the write-back value
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

endmodule
